// ==== design/ecc_pkg.sv ====
package ecc_pkg;

    // ====================
    // geometry
    // ====================
    localparam int DATA_WIDTH   = 29;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;  // check bits sit above the data
    localparam int ADDR_WIDTH   = 6;
    localparam int DEPTH        = 1 << ADDR_WIDTH;
    localparam int CNT_WIDTH    = 16;

    // ====================
    // command and status
    // ====================
    typedef enum logic [1:0] {
        CMD_IDLE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } ecc_cmd_e;

    typedef enum logic [1:0] {
        ST_OK            = 2'd0,
        ST_CORRECTED     = 2'd1,
        ST_UNCORRECTABLE = 2'd2
    } ecc_status_e;

    // ====================
    // code table
    // ====================
    // syndrome column of each data bit, bit 28 leads the concatenation
    // every column has odd weight so a double error never aliases a single one
    localparam logic [DATA_WIDTH-1:0][PARITY_WIDTH-1:0] DATA_COLS = {
        7'b0100011, 7'b1100010, 7'b1100001, 7'b0011111,  // bits 28 down to 25
        7'b1011110, 7'b1011101, 7'b0011100, 7'b1011011,  // bits 24 down to 21
        7'b0011010, 7'b0011001, 7'b1011000, 7'b1010111,  // bits 20 down to 17
        7'b0010110, 7'b0010101, 7'b1010100, 7'b0010011,  // bits 16 down to 13
        7'b1010010, 7'b1010001, 7'b1001111, 7'b0001110,  // bits 12 down to 9
        7'b0001101, 7'b1001100, 7'b0001011, 7'b1001010,  // bits 8 down to 5
        7'b1001001, 7'b0000111, 7'b1000110, 7'b1000101,  // bits 4 down to 1
        7'b1000011                                       // bit 0
    };

    // check bit k is the parity of all data bits whose column has bit k set
    function automatic logic [PARITY_WIDTH-1:0] ecc_check_bits(
        input logic [DATA_WIDTH-1:0] data
    );
        logic [PARITY_WIDTH-1:0] p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (data[i]) begin
                p = p ^ DATA_COLS[i];
            end
        end
        return p;
    endfunction

endpackage

// ==== design/ecc_rd_if.sv ====
`timescale 1ns/1ns

interface ecc_rd_if import ecc_pkg::*; ();

    logic                  valid;   // one cycle per read in the check stage
    logic [ADDR_WIDTH-1:0] addr;
    logic [CODE_WIDTH-1:0] code;    // raw codeword as it sits in the array
    logic                  bypass;

    modport src (
        output valid,
        output addr,
        output code,
        output bypass
    );

    modport dst (
        input valid,
        input addr,
        input code,
        input bypass
    );

endinterface

// ==== design/ecc_code_ram.sv ====
`timescale 1ns/1ns

module ecc_code_ram import ecc_pkg::*; (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [CODE_WIDTH-1:0] wcode,
    input  logic                  re,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [CODE_WIDTH-1:0] rcode
);

    logic [CODE_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wcode;
        end
    end

    // read data holds between reads so the check stage sees a stable word
    always_ff @(posedge clk) begin
        if (re) begin
            rcode <= mem[raddr];  // a write on the same edge is not seen here
        end
    end

endmodule

// ==== design/ecc_mem_ctrl.sv ====
`timescale 1ns/1ns

module ecc_mem_ctrl import ecc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  ecc_cmd_e              cmd,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [CODE_WIDTH-1:0] flip,
    input  logic                  bypass,
    output logic                  we,
    output logic [ADDR_WIDTH-1:0] waddr,
    output logic [CODE_WIDTH-1:0] wcode,
    output logic                  re,
    output logic [ADDR_WIDTH-1:0] raddr,
    input  logic [CODE_WIDTH-1:0] rcode,
    ecc_rd_if.src                 rd
);

    logic [CODE_WIDTH-1:0] clean_code;

    // ====================
    // write path
    // ====================
    assign clean_code = {ecc_check_bits(wdata), wdata};

    assign we    = (cmd == CMD_WRITE);
    assign waddr = addr;
    assign wcode = clean_code ^ flip;  // diagnostic corruption of the stored word

    // ====================
    // read launch
    // ====================
    assign re    = (cmd == CMD_READ);
    assign raddr = addr;

    // read qualifiers ride one stage behind to meet the registered RAM output
    always_ff @(posedge clk) begin
        if (rst) begin
            rd.valid <= 1'b0;
        end else begin
            rd.valid <= re;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rd.addr   <= addr;
            rd.bypass <= bypass;
        end
    end

    assign rd.code = rcode;

endmodule

// ==== design/ecc_check.sv ====
`timescale 1ns/1ns

module ecc_check import ecc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    ecc_rd_if.dst                   rd,
    output logic                    rvalid,
    output logic [DATA_WIDTH-1:0]   rdata,
    output logic [PARITY_WIDTH-1:0] rparity,
    output ecc_status_e             rstatus,
    output logic                    chk_valid,
    output ecc_status_e             chk_status,
    output logic [ADDR_WIDTH-1:0]   chk_addr
);

    logic [DATA_WIDTH-1:0]   st_data;
    logic [PARITY_WIDTH-1:0] st_parity;
    logic [PARITY_WIDTH-1:0] syndrome;
    logic [DATA_WIDTH-1:0]   fix_mask;
    ecc_status_e             fix_status;
    logic [ADDR_WIDTH-1:0]   res_addr;

    assign st_data   = rd.code[DATA_WIDTH-1:0];
    assign st_parity = rd.code[CODE_WIDTH-1:DATA_WIDTH];
    assign syndrome  = st_parity ^ ecc_check_bits(st_data);

    // ====================
    // syndrome decode
    // ====================
    always_comb begin
        fix_mask   = '0;
        fix_status = ST_UNCORRECTABLE;  // anything not matched below is a double error
        if (syndrome == '0) begin
            fix_status = ST_OK;
        end else if ($countones(syndrome) == 1) begin
            fix_status = ST_CORRECTED;  // a check bit flipped and the data is intact
        end else begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (syndrome == DATA_COLS[i]) begin
                    fix_mask[i] = 1'b1;
                    fix_status  = ST_CORRECTED;
                end
            end
        end
        if (rd.bypass) begin
            fix_mask   = '0;
            fix_status = ST_OK;  // raw data out and no flags
        end
    end

    // ====================
    // result register
    // ====================
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid  <= 1'b0;
            rstatus <= ST_OK;
        end else begin
            rvalid <= rd.valid;
            if (rd.valid) begin
                rstatus <= fix_status;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.valid) begin
            rdata    <= st_data ^ fix_mask;
            rparity  <= st_parity;  // stored check bits shown as is
            res_addr <= rd.addr;
        end
    end

    assign chk_valid  = rvalid;
    assign chk_status = rstatus;
    assign chk_addr   = res_addr;

endmodule

// ==== design/ecc_err_log.sv ====
`timescale 1ns/1ns

module ecc_err_log import ecc_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  chk_valid,
    input  ecc_status_e           chk_status,
    input  logic [ADDR_WIDTH-1:0] chk_addr,
    output logic [CNT_WIDTH-1:0]  sbit_count,
    output logic [CNT_WIDTH-1:0]  dbit_count,
    output logic [ADDR_WIDTH-1:0] last_err_addr
);

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = chk_valid && (chk_status == ST_CORRECTED);
    assign dbit_hit = chk_valid && (chk_status == ST_UNCORRECTABLE);

    // both counters stick at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else begin
            if (sbit_hit && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_hit) begin
                if (dbit_count != '1) begin
                    dbit_count <= dbit_count + 1'b1;
                end
                last_err_addr <= chk_addr;  // most recent uncorrectable read wins
            end
        end
    end

endmodule

// ==== design/ecc_mem_top.sv ====
`timescale 1ns/1ns

module ecc_mem_top import ecc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  ecc_cmd_e                cmd,
    input  logic [ADDR_WIDTH-1:0]   addr,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [CODE_WIDTH-1:0]   flip,
    input  logic                    bypass,
    output logic                    rvalid,
    output logic [DATA_WIDTH-1:0]   rdata,
    output logic [PARITY_WIDTH-1:0] rparity,
    output ecc_status_e             rstatus,
    output logic [CNT_WIDTH-1:0]    sbit_count,
    output logic [CNT_WIDTH-1:0]    dbit_count,
    output logic [ADDR_WIDTH-1:0]   last_err_addr
);

    logic                  we;
    logic [ADDR_WIDTH-1:0] waddr;
    logic [CODE_WIDTH-1:0] wcode;
    logic                  re;
    logic [ADDR_WIDTH-1:0] raddr;
    logic [CODE_WIDTH-1:0] rcode;
    logic                  chk_valid;
    ecc_status_e           chk_status;
    logic [ADDR_WIDTH-1:0] chk_addr;

    ecc_rd_if rd_bus ();  // raw codeword from the RAM stage to the checker

    ecc_mem_ctrl i_ctrl (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .addr   (addr),
        .wdata  (wdata),
        .flip   (flip),
        .bypass (bypass),
        .we     (we),
        .waddr  (waddr),
        .wcode  (wcode),
        .re     (re),
        .raddr  (raddr),
        .rcode  (rcode),
        .rd     (rd_bus)
    );

    ecc_code_ram i_ram (
        .clk   (clk),
        .we    (we),
        .waddr (waddr),
        .wcode (wcode),
        .re    (re),
        .raddr (raddr),
        .rcode (rcode)
    );

    ecc_check i_check (
        .clk        (clk),
        .rst        (rst),
        .rd         (rd_bus),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rparity    (rparity),
        .rstatus    (rstatus),
        .chk_valid  (chk_valid),
        .chk_status (chk_status),
        .chk_addr   (chk_addr)
    );

    ecc_err_log i_log (
        .clk           (clk),
        .rst           (rst),
        .chk_valid     (chk_valid),
        .chk_status    (chk_status),
        .chk_addr      (chk_addr),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

// ==== testbench/tb_ecc_mem.sv ====
`timescale 1ns/1ns

module tb_ecc_mem import ecc_pkg::*; ();

    localparam int N_TESTS         = 12;
    localparam int CLK_PERIOD      = 40;
    localparam int WATCHDOG_CYCLES = N_TESTS * 6 + 50;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [CODE_WIDTH-1:0] flip;
        logic                  bypass;
        ecc_status_e           status;
    } vec_t;

    logic                    clk = 1'b0;
    logic                    rst;
    ecc_cmd_e                cmd;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [CODE_WIDTH-1:0]   flip;
    logic                    bypass;
    logic                    rvalid;
    logic [DATA_WIDTH-1:0]   rdata;
    logic [PARITY_WIDTH-1:0] rparity;
    ecc_status_e             rstatus;
    logic [CNT_WIDTH-1:0]    sbit_count;
    logic [CNT_WIDTH-1:0]    dbit_count;
    logic [ADDR_WIDTH-1:0]   last_err_addr;

    vec_t                    vecs [N_TESTS];
    logic [DATA_WIDTH-1:0]   wdata_tab [N_TESTS];
    int                      pend_idx [$];
    int                      pend_cyc [$];
    int                      cyc = 0;
    int                      errors = 0;
    int                      checks = 0;

    // syndrome column per data bit with bit 0 first
    logic [PARITY_WIDTH-1:0] cols [DATA_WIDTH] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111, 7'b1001001, 7'b1001010,
        7'b0001011, 7'b1001100, 7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001,
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101, 7'b0010110, 7'b1010111,
        7'b1011000, 7'b0011001, 7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101,
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010, 7'b0100011
    };

    ecc_mem_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .addr          (addr),
        .wdata         (wdata),
        .flip          (flip),
        .bypass        (bypass),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rparity       (rparity),
        .rstatus       (rstatus),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // ====================
    // reference model
    // ====================
    function automatic logic [PARITY_WIDTH-1:0] model_parity(input logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        for (int k = 0; k < PARITY_WIDTH; k++) begin
            p[k] = 1'b0;
            for (int i = 0; i < DATA_WIDTH; i++) begin
                p[k] = p[k] ^ (d[i] & cols[i][k]);
            end
        end
        return p;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_data(input int idx);
        logic [DATA_WIDTH-1:0] stored;
        stored = wdata_tab[idx] ^ vecs[idx].flip[DATA_WIDTH-1:0];
        if (vecs[idx].bypass || vecs[idx].status == ST_UNCORRECTABLE) begin
            return stored;  // the corrupted word comes back uncorrected
        end
        return wdata_tab[idx];
    endfunction

    task automatic load_table();
        vecs[0]  = '{6'h00, 36'h0, 1'b0, ST_OK};
        vecs[1]  = '{6'h01, 36'h0, 1'b0, ST_OK};
        vecs[2]  = '{6'h02, 36'h1 << 0, 1'b0, ST_CORRECTED};
        vecs[3]  = '{6'h03, 36'h1 << 28, 1'b0, ST_CORRECTED};
        vecs[4]  = '{6'h14, 36'h1 << 13, 1'b0, ST_CORRECTED};
        vecs[5]  = '{6'h05, 36'h1 << 29, 1'b0, ST_CORRECTED};  // lowest check bit
        vecs[6]  = '{6'h3f, 36'h1 << 35, 1'b0, ST_CORRECTED};
        vecs[7]  = '{6'h07, (36'h1 << 3) | (36'h1 << 20), 1'b0, ST_UNCORRECTABLE};
        vecs[8]  = '{6'h21, (36'h1 << 5) | (36'h1 << 31), 1'b0, ST_UNCORRECTABLE};
        vecs[9]  = '{6'h2b, (36'h1 << 0) | (36'h1 << 28), 1'b0, ST_UNCORRECTABLE};
        vecs[10] = '{6'h0a, 36'h1 << 7, 1'b1, ST_OK};
        vecs[11] = '{6'h0b, (36'h1 << 1) | (36'h1 << 2), 1'b1, ST_OK};
        for (int i = 0; i < N_TESTS; i++) begin
            wdata_tab[i] = DATA_WIDTH'($urandom);
        end
    endtask

    // ====================
    // compare tasks
    // ====================
    task automatic check_data(input logic [DATA_WIDTH-1:0] got, exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_parity(input logic [PARITY_WIDTH-1:0] got, exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input ecc_status_e got, exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %s expected %s",
                     $time, msg, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic check_count(input logic [CNT_WIDTH-1:0] got, exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input logic [ADDR_WIDTH-1:0] got, exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic drive_cmd(input ecc_cmd_e c, input int idx);
        @(posedge clk);
        #2;
        cmd    = c;
        addr   = vecs[idx].addr;
        wdata  = wdata_tab[idx];
        flip   = vecs[idx].flip;
        bypass = vecs[idx].bypass;
    endtask

    // each rvalid retires the oldest outstanding read
    always @(negedge clk) begin
        int idx;
        int launch;
        logic [PARITY_WIDTH-1:0] exp_par;
        if (!rst && rvalid) begin
            if (pend_idx.size() == 0) begin
                $display("rvalid went high at %0t with no read outstanding", $time);
                errors++;
            end else begin
                idx    = pend_idx.pop_front();
                launch = pend_cyc.pop_front();
                if (cyc != launch + 2) begin
                    $display("read of entry %0d returned %0d cycles after its strobe",
                             idx, cyc - launch);
                    errors++;
                end
                exp_par = model_parity(wdata_tab[idx]) ^ vecs[idx].flip[CODE_WIDTH-1:DATA_WIDTH];
                check_data(rdata, expected_data(idx), $sformatf("rdata of entry %0d", idx));
                check_status(rstatus, vecs[idx].status, $sformatf("rstatus of entry %0d", idx));
                check_parity(rparity, exp_par, $sformatf("rparity of entry %0d", idx));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: reads did not complete within %0d clock cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    // ====================
    // main sequence
    // ====================
    initial begin
        int exp_sbit;
        int exp_dbit;
        logic [ADDR_WIDTH-1:0] exp_last;
        exp_sbit = 0;
        exp_dbit = 0;
        exp_last = '0;
        void'($urandom(32'h5ce3));
        rst    = 1'b1;
        cmd    = CMD_IDLE;
        addr   = '0;
        wdata  = '0;
        flip   = '0;
        bypass = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < N_TESTS; i++) begin
            drive_cmd(CMD_WRITE, i);
        end
        for (int i = 0; i < N_TESTS; i++) begin
            drive_cmd(CMD_READ, i);  // issued back to back with two reads in flight
            pend_idx.push_back(i);
            pend_cyc.push_back(cyc);
        end
        @(posedge clk);
        #2;
        cmd = CMD_IDLE;

        while (pend_idx.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);  // log updates on the edge after rvalid

        for (int i = 0; i < N_TESTS; i++) begin
            if (!vecs[i].bypass && vecs[i].status == ST_CORRECTED) begin
                exp_sbit++;
            end else if (!vecs[i].bypass && vecs[i].status == ST_UNCORRECTABLE) begin
                exp_dbit++;
                exp_last = vecs[i].addr;
            end
        end
        check_count(sbit_count, CNT_WIDTH'(exp_sbit), "sbit_count");
        check_count(dbit_count, CNT_WIDTH'(exp_dbit), "dbit_count");
        check_addr(last_err_addr, exp_last, "last_err_addr");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/ecc_pkg.sv
design/ecc_rd_if.sv
design/ecc_code_ram.sv
design/ecc_mem_ctrl.sv
design/ecc_check.sv
design/ecc_err_log.sv
design/ecc_mem_top.sv
testbench/tb_ecc_mem.sv

// ==== Makefile ====
TOP := tb_ecc_mem

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f design/*.sv testbench/*.sv
	verilator --binary --timing -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module ecc_mem_top

clean:
	rm -rf obj_dir
